/* list.f */
hw/miner_pkg.sv
hw/bus_decode.sv
hw/header_loader.sv
hw/work_dispatch.sv
hw/result_capture.sv
hw/register_readback.sv
hw/miner_top.sv
bench/tb_clock.sv
bench/tb_miner_top.sv

/* Makefile */
# Verilator build and run of the miner controller testbench
VERILATOR ?= verilator
TOP ?= tb_miner_top
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Finished with errors
PASS_MSG ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED: no result line"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_miner_top.sv */
// Miner controller testbench with lane model, bus tasks, directed tests and cycle limit
module tb_miner_top;
	import miner_pkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int MAX_CYCLES = 2000;	// Twice the length of six loads and about 250 reads

	logic clk;
	logic rst_n;
	logic write;
	logic read;
	logic chipselect;
	logic [7:0] address;
	byte_t writedata;
	byte_t readdata;
	work_t work;
	logic work_valid;
	lane_result_t [NUM_MINERS-1:0] lane_results;

	int seed = 44;
	int cycle_count = 0;
	byte_t exp_hdr [HEADER_BYTES];
	nonce_t [NUM_MINERS-1:0] lane_count = '0;
	logic [NUM_MINERS-1:0] find_mask = '0;
	nonce_t find_nonce = '0;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	miner_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.write(write),
		.read(read),
		.chipselect(chipselect),
		.address(address),
		.writedata(writedata),
		.readdata(readdata),
		.work(work),
		.work_valid(work_valid),
		.lane_results(lane_results)
	);

	// Lane model counting up from each lane's start nonce
	always @(posedge clk) begin
		#1;
		for (int k = 0; k < NUM_MINERS; k++) begin
			if (work_valid)
				lane_count[k] = work.start_nonce[k];
			else
				lane_count[k] = lane_count[k] + 32'd1;
		end
	end

	always_comb begin
		for (int k = 0; k < NUM_MINERS; k++) begin
			lane_results[k].found = find_mask[k];
			lane_results[k].nonce = find_mask[k] ? find_nonce : lane_count[k];	// Forced find value
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			stop_on_error();
		end
	end

	task automatic stop_on_error();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, got, expected);
			stop_on_error();
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic bus_write(input logic [7:0] addr, input byte_t data);
		chipselect = 1'b1;
		write = 1'b1;
		address = addr;
		writedata = data;
		tick();
		chipselect = 1'b0;
		write = 1'b0;
	endtask

	task automatic expect_read(input logic [7:0] addr, input byte_t expected);
		chipselect = 1'b1;
		read = 1'b1;
		address = addr;
		tick();
		chipselect = 1'b0;
		read = 1'b0;
		check_equal($sformatf("readdata at address %0d", addr), 32'(readdata), 32'(expected));
	endtask

	// Random header with the nonce placed in bytes 44 to 47
	task automatic make_header(input nonce_t nonce);
		for (int i = 0; i < HEADER_BYTES; i++)
			exp_hdr[i] = byte_t'($random(seed));
		for (int b = 0; b < 4; b++)
			exp_hdr[44 + b] = nonce[8*b +: 8];
	endtask

	task automatic write_header_bytes(input int skip);
		for (int i = 0; i < HEADER_BYTES; i++) begin
			if (i == skip)
				exp_hdr[i] = 8'h00;	// Left at the cleared value
			else
				bus_write(8'(i), exp_hdr[i]);
		end
	endtask

	task automatic load_header(input int skip);
		bus_write(8'(ADDR_START), 8'h01);
		write_header_bytes(skip);
	endtask

	// The cycle of the last header write counts as the first
	task automatic wait_work();
		int cycles;
		cycles = 1;
		while (work_valid !== 1'b1 && cycles < 8) begin
			tick();
			cycles++;
		end
		if (work_valid !== 1'b1) begin
			$display("work_valid did not rise within 8 cycles of the last header byte");
			stop_on_error();
		end
		check_equal("work_valid delay in cycles", 32'(cycles), 32'd2);
	endtask

	task automatic check_single_pulse();
		repeat (4) begin
			tick();
			check_equal("work_valid", 32'(work_valid), 32'd0);
		end
	endtask

	task automatic check_start_nonces(input nonce_t nonce);
		nonce_t expected;
		for (int k = 0; k < NUM_MINERS; k++) begin
			expected = nonce + 32'(k) * 32'd1_000_000;	// Wraps at 2^32
			check_equal($sformatf("work.start_nonce[%0d]", k), work.start_nonce[k], expected);
			for (int b = 0; b < 4; b++)
				expect_read(8'(ADDR_NONCE_BASE + 4*k + b), expected[8*b +: 8]);
		end
	endtask

	task automatic check_results(input nonce_t [NUM_MINERS-1:0] nonces,
		input logic [NUM_MINERS-1:0] found);
		for (int k = 0; k < NUM_MINERS; k++) begin
			for (int b = 0; b < 4; b++)
				expect_read(8'(ADDR_RESULT_BASE + RESULT_STRIDE*k + b), nonces[k][8*b +: 8]);
			expect_read(8'(ADDR_RESULT_BASE + RESULT_STRIDE*k + 4), {7'd0, found[k]});
		end
	endtask

	task automatic test_reset_state();
		check_equal("readdata", 32'(readdata), 32'd0);
		expect_read(8'(ADDR_STATUS), 8'h00);
		expect_read(8'(ADDR_START), 8'h00);
		repeat (4) begin
			check_equal("work_valid", 32'(work_valid), 32'd0);
			tick();
		end
	endtask

	task automatic test_header_readback();
		make_header(nonce_t'($random(seed)));
		bus_write(8'd10, 8'hA5);	// Idle write is dropped
		load_header(10);
		wait_work();
		check_single_pulse();
		for (int i = 0; i < HEADER_BYTES; i++) begin
			check_equal($sformatf("work.header byte %0d", i),
				32'(work.header.bytes[i]), 32'(exp_hdr[i]));
			expect_read(8'(i), exp_hdr[i]);
		end
		bus_write(8'd10, 8'h5A);
		expect_read(8'd10, 8'h00);
		expect_read(8'(ADDR_STATUS), 8'h02);
	endtask

	task automatic test_start_nonces();
		nonce_t nonces [2];
		nonces[0] = nonce_t'($random(seed));
		nonces[1] = 32'hFFF0_0000;	// Lanes 2 to 4 wrap
		for (int t = 0; t < 2; t++) begin
			make_header(nonces[t]);
			load_header(-1);
			wait_work();
			check_single_pulse();
			check_start_nonces(nonces[t]);
		end
	endtask

	task automatic test_find_capture();
		nonce_t [NUM_MINERS-1:0] exp_nonce;
		make_header(nonce_t'($random(seed)));
		load_header(-1);
		wait_work();
		check_single_pulse();
		expect_read(8'(ADDR_START), 8'h01);
		repeat (2 + ($random(seed) & 3)) tick();
		find_nonce = 32'hC0FF_EE42;
		find_mask = 5'b00100;
		for (int k = 0; k < NUM_MINERS; k++)
			exp_nonce[k] = (k == 2) ? find_nonce : lane_count[k];
		tick();
		find_mask = '0;
		check_results(exp_nonce, 5'b00100);
		expect_read(8'(ADDR_START), 8'h02);
		// A later find on lane 0 must not overwrite the snapshot
		find_nonce = 32'h0BAD_F00D;
		find_mask = 5'b00001;
		tick();
		find_mask = '0;
		check_results(exp_nonce, 5'b00100);
	endtask

	task automatic test_restart_clears();
		make_header(nonce_t'($random(seed)));
		find_nonce = 32'h7777_0000;
		find_mask = '1;	// Finds during the load and before work_valid
		load_header(-1);
		wait_work();
		find_mask = '0;
		check_single_pulse();
		expect_read(8'(ADDR_START), 8'h01);
		check_results('0, '0);
		expect_read(8'(ADDR_STATUS), 8'h02);
	endtask

	task automatic test_read_rules();
		logic [7:0] unmapped [8];
		unmapped = '{8'd96, 8'd100, 8'd103, 8'd124, 8'd147, 8'd173, 8'd200, 8'd255};
		expect_read(8'(ADDR_STATUS), 8'h02);
		make_header(nonce_t'($random(seed)));
		bus_write(8'(ADDR_START), 8'h01);
		// Reads while loading keep the last value
		expect_read(8'(ADDR_STATUS), 8'h02);
		expect_read(8'(ADDR_START), 8'h02);
		expect_read(8'd5, 8'h02);
		write_header_bytes(-1);
		wait_work();
		check_single_pulse();
		foreach (unmapped[i]) begin
			expect_read(8'(ADDR_STATUS), 8'h02);
			expect_read(unmapped[i], 8'h00);
		end
	endtask

	initial begin
		write = 1'b0;
		read = 1'b0;
		chipselect = 1'b0;
		address = '0;
		writedata = '0;
		wait (rst_n === 1'b1);
		tick();
		test_reset_state();
		test_header_readback();
		test_start_nonces();
		test_find_capture();
		test_restart_clears();
		test_read_rules();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
// Bench clock and reset generator, period 40 with reset held for 10 cycles
module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2 rst_n = 1'b1;	// Released clear of the edge
	end

endmodule

/* hw/miner_top.sv */
// Miner controller top level: bus decode, header load, work dispatch, capture and readback
module miner_top (
	input logic clk,
	input logic rst_n,
	input logic write,
	input logic read,
	input logic chipselect,
	input logic [7:0] address,
	input miner_pkg::byte_t writedata,
	output miner_pkg::byte_t readdata,
	output miner_pkg::work_t work,
	output logic work_valid,
	input miner_pkg::lane_result_t [miner_pkg::NUM_MINERS-1:0] lane_results
);
	import miner_pkg::*;

	bus_cmd_t cmd;
	header_u header;
	logic loading;
	logic loaded;
	logic load_done;
	lane_result_t [NUM_MINERS-1:0] results;
	logic armed;
	logic stopped;

	bus_decode u_bus_decode (
		.write(write),
		.read(read),
		.chipselect(chipselect),
		.address(address),
		.writedata(writedata),
		.cmd(cmd)
	);

	header_loader u_header_loader (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.header(header),
		.loading(loading),
		.loaded(loaded),
		.load_done(load_done)
	);

	work_dispatch u_work_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.header(header),
		.load_done(load_done),
		.work(work),
		.work_valid(work_valid)
	);

	result_capture u_result_capture (
		.clk(clk),
		.rst_n(rst_n),
		.work_valid(work_valid),
		.loading(loading),
		.lane_results(lane_results),
		.results(results),
		.armed(armed),
		.stopped(stopped)
	);

	// Start nonces read back from the issued work
	register_readback u_register_readback (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.address(address),
		.header(header),
		.start_nonce(work.start_nonce),
		.results(results),
		.loading(loading),
		.loaded(loaded),
		.armed(armed),
		.stopped(stopped),
		.readdata(readdata)
	);

endmodule

/* hw/register_readback.sv */
// Register readback: address map over header, start nonces, results and status flags
module register_readback (
	input logic clk,
	input logic rst_n,
	input miner_pkg::bus_cmd_t cmd,
	input logic [7:0] address,
	input miner_pkg::header_u header,
	input miner_pkg::nonce_t [miner_pkg::NUM_MINERS-1:0] start_nonce,
	input miner_pkg::lane_result_t [miner_pkg::NUM_MINERS-1:0] results,
	input logic loading,
	input logic loaded,
	input logic armed,
	input logic stopped,
	output miner_pkg::byte_t readdata
);
	import miner_pkg::*;

	logic [7:0] nonce_off;
	logic [7:0] res_off;
	logic [2:0] nonce_lane;
	logic [1:0] nonce_b;
	logic [2:0] res_lane;
	logic [2:0] res_b;
	logic in_nonce;
	logic in_result;
	byte_t rd_byte;

	// Lane and byte within lane for the nonce block
	assign nonce_off = 8'(address - ADDR_NONCE_BASE);
	assign nonce_lane = nonce_off[4:2];
	assign nonce_b = nonce_off[1:0];

	// Result block has five bytes per lane
	assign res_off = 8'(address - ADDR_RESULT_BASE);
	assign res_lane = 3'(res_off / RESULT_STRIDE);
	assign res_b = 3'(res_off % RESULT_STRIDE);

	assign in_nonce = (address >= ADDR_NONCE_BASE) &&
		(address < ADDR_NONCE_BASE + 4 * NUM_MINERS);
	assign in_result = (address >= ADDR_RESULT_BASE) &&
		(address < ADDR_RESULT_BASE + RESULT_STRIDE * NUM_MINERS);

	always_comb begin
		rd_byte = '0;	// Unmapped addresses read zero
		if (address <= ADDR_HEADER_LAST) begin
			rd_byte = header.bytes[cmd.index];
		end else if (address == ADDR_STATUS) begin
			rd_byte = {6'd0, loaded, loading};
		end else if (address == ADDR_START) begin
			rd_byte = {6'd0, stopped, armed};
		end else if (in_nonce) begin
			rd_byte = start_nonce[nonce_lane][{nonce_b, 3'b000} +: 8];	// LSB first
		end else if (in_result) begin
			if (res_b == 3'd4)
				rd_byte = {7'd0, results[res_lane].found};
			else
				rd_byte = results[res_lane].nonce[{res_b[1:0], 3'b000} +: 8];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			readdata <= '0;
		else if (cmd.rd && !loading)
			readdata <= rd_byte;	// Held through loading
	end

endmodule

/* hw/result_capture.sv */
// Result capture: arms on new work and snapshots every lane on the first find
module result_capture (
	input logic clk,
	input logic rst_n,
	input logic work_valid,
	input logic loading,
	input miner_pkg::lane_result_t [miner_pkg::NUM_MINERS-1:0] lane_results,
	output miner_pkg::lane_result_t [miner_pkg::NUM_MINERS-1:0] results,
	output logic armed,
	output logic stopped
);
	import miner_pkg::*;

	logic any_found;

	always_comb begin
		any_found = 1'b0;
		for (int k = 0; k < NUM_MINERS; k++) begin
			any_found = any_found | lane_results[k].found;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
			stopped <= 1'b0;
			results <= '0;
		end else if (loading) begin
			// A new header invalidates the last search
			armed <= 1'b0;
			stopped <= 1'b0;
			results <= '0;
		end else if (work_valid) begin
			armed <= 1'b1;
		end else if (armed && any_found) begin
			results <= lane_results;	// All lanes, as seen in the find cycle
			armed <= 1'b0;
			stopped <= 1'b1;
		end
	end

	// Search is either running or finished, never both
	assert property (@(posedge clk) disable iff (!rst_n) !(armed && stopped))
		else $error("armed and stopped both set");

endmodule

/* hw/work_dispatch.sv */
// Work dispatch: per-lane start nonces from the header nonce and the work strobe
module work_dispatch (
	input logic clk,
	input logic rst_n,
	input miner_pkg::header_u header,
	input logic load_done,
	output miner_pkg::work_t work,
	output logic work_valid
);
	import miner_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			work_valid <= 1'b0;
		else
			work_valid <= load_done;	// One strobe per completed load
	end

	always_ff @(posedge clk) begin
		if (load_done) begin
			work.header <= header;
			// Lane k starts k ranges above the header nonce, wrapping at 2^32
			for (int k = 0; k < NUM_MINERS; k++) begin
				work.start_nonce[k] <= header.fields.nonce + nonce_t'(k) * NONCE_RANGE;
			end
		end
	end

	// Lanes take the work on a single edge
	assert property (@(posedge clk) disable iff (!rst_n) work_valid |=> !work_valid)
		else $error("work_valid longer than one cycle");

endmodule

/* hw/header_loader.sv */
// Header loader: header byte buffer and the idle, loading and loaded sequence
module header_loader (
	input logic clk,
	input logic rst_n,
	input miner_pkg::bus_cmd_t cmd,
	output miner_pkg::header_u header,
	output logic loading,
	output logic loaded,
	output logic load_done
);
	import miner_pkg::*;

	logic start_load;
	logic byte_wr;
	logic last_byte;

	assign start_load = cmd.start_wr && !loading;	// Restart ignored mid-load
	assign byte_wr = cmd.hdr_wr && loading;
	assign last_byte = byte_wr && (cmd.index == 7'(ADDR_HEADER_LAST));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			loading <= 1'b0;
			loaded <= 1'b0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;	// Single-cycle strobe
			if (start_load) begin
				loading <= 1'b1;
				loaded <= 1'b0;
			end else if (last_byte) begin
				// Byte 95 closes the load
				loading <= 1'b0;
				loaded <= 1'b1;
				load_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_load)
			header <= '0;	// Fresh header for each load
		else if (byte_wr)
			header.bytes[cmd.index] <= cmd.data;
	end

	// The last byte ends loading at the same edge that raises load_done
	assert property (@(posedge clk) disable iff (!rst_n) load_done |-> !loading)
		else $error("load_done high while loading");

endmodule

/* hw/bus_decode.sv */
// Bus decoder: classifies host bus cycles into header writes, start commands and reads
module bus_decode (
	input logic write,
	input logic read,
	input logic chipselect,
	input logic [7:0] address,
	input miner_pkg::byte_t writedata,
	output miner_pkg::bus_cmd_t cmd
);
	import miner_pkg::*;

	logic wr_sel;

	assign wr_sel = write && chipselect;

	always_comb begin
		// Only header addresses count as header writes
		cmd.hdr_wr = wr_sel && (address <= ADDR_HEADER_LAST);

		// Start needs bit 0 set, other data is a no-op
		cmd.start_wr = wr_sel && (address == ADDR_START) && writedata[0];

		cmd.rd = read && chipselect;
		cmd.data = writedata;
		cmd.index = address[6:0];	// Meaningful only with hdr_wr or a header read
	end

endmodule

/* hw/miner_pkg.sv */
// Bus address map, miner sizing, header union and the command, result and work types
package miner_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] nonce_t;

	// Miner sizing
	localparam int NUM_MINERS = 5;
	localparam nonce_t NONCE_RANGE = 32'd1_000_000;	// Nonces searched per lane

	// Header layout
	localparam int HEADER_BYTES = 96;
	localparam int HEADER_BITS = HEADER_BYTES * 8;
	localparam int NONCE_LSB = 352;	// Nonce sits in header bytes 44 to 47

	// Register map of the host bus
	localparam int ADDR_HEADER_LAST = 95;
	localparam int ADDR_STATUS = 101;	// Load flags
	localparam int ADDR_START = 102;	// Write starts a load, read gives search flags
	localparam int ADDR_NONCE_BASE = 104;	// Four bytes per lane
	localparam int ADDR_RESULT_BASE = 148;
	localparam int RESULT_STRIDE = 5;	// Nonce bytes then found flag

	// Named view of the header, most significant field first
	typedef struct packed {
		logic [HEADER_BITS-NONCE_LSB-33:0] tail;
		nonce_t nonce;
		logic [NONCE_LSB-1:0] head;
	} header_fields_t;

	// Byte view for the bus, field view for work setup
	typedef union packed {
		byte_t [HEADER_BYTES-1:0] bytes;
		header_fields_t fields;
	} header_u;

	// One bus cycle after decode
	typedef struct packed {
		logic hdr_wr;
		logic start_wr;
		logic rd;
		byte_t data;
		logic [6:0] index;	// Header byte number
	} bus_cmd_t;

	typedef struct packed {
		logic found;
		nonce_t nonce;
	} lane_result_t;

	// Work handed to the lanes on each load
	typedef struct packed {
		header_u header;
		nonce_t [NUM_MINERS-1:0] start_nonce;
	} work_t;

endpackage
